// File: logic/ldst_config.svh
`ifndef LDST_CONFIG_SVH
`define LDST_CONFIG_SVH

// Physical register tag and ROB index widths.
`define PRF_IDX_W 6
`define ROB_IDX_W 5

// Store queue geometry.
// The depth must stay a power of two so that index arithmetic wraps.
`define SQ_DEPTH 8
`define SQ_IDX_W 3

// Data memory size in doublewords.
`define DMEM_WORDS 64
`define DMEM_IDX_W 6

// Byte offset bits below the doubleword index.
`define DW_OFFSET_W 3

`endif

// File: logic/ldst_pkg.sv
`include "ldst_config.svh"

package ldst_pkg;

  // One request from the issue stage, shared by loads and stores.
  typedef struct packed {
    logic [63:0]            opa;
    logic [63:0]            opb;
    logic [31:0]            inst;
    logic [`PRF_IDX_W-1:0]  dest_tag;
    logic [`ROB_IDX_W-1:0]  rob_idx;
  } ldst_req_t;

  // Load writeback toward the register file and the ROB.
  typedef struct packed {
    logic [63:0]            data;
    logic [`PRF_IDX_W-1:0]  dest_tag;
    logic [`ROB_IDX_W-1:0]  rob_idx;
  } ldst_result_t;

  // A store waiting for retirement.
  // addr_vld is set once the store has executed.
  typedef struct packed {
    logic                   valid;
    logic                   addr_vld;
    logic [63:0]            addr;
    logic [63:0]            data;
  } sq_entry_t;

endpackage

// File: logic/mem_pkg.sv
package mem_pkg;

  // Write port request, driven by the store queue on retire.
  typedef struct packed {
    logic         en;
    logic [63:0]  addr;
    logic [63:0]  data;
  } mem_wr_t;

  // Read port request, driven by the lsq for loads that miss the queue.
  typedef struct packed {
    logic         en;
    logic [63:0]  addr;
  } mem_rd_t;

endpackage

// File: logic/data_mem.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module data_mem import mem_pkg::*; (
  input  logic         clk,
  input  logic         rst_i,
  input  mem_rd_t      rd_i,
  input  mem_wr_t      wr_i,
  output logic [63:0]  rdata_o
);

  logic [63:0]             mem [`DMEM_WORDS];
  logic [`DMEM_IDX_W-1:0]  rd_idx;
  logic [`DMEM_IDX_W-1:0]  wr_idx;

  // Doubleword index, the low byte offset bits are ignored.
  assign rd_idx = rd_i.addr[`DW_OFFSET_W +: `DMEM_IDX_W];
  assign wr_idx = wr_i.addr[`DW_OFFSET_W +: `DMEM_IDX_W];

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < `DMEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_i.en) begin
      mem[wr_idx] <= wr_i.data;
    end
  end

  // Read returns the contents from before a same-edge write.
  always_ff @(posedge clk) begin
    if (rd_i.en) begin
      rdata_o <= mem[rd_idx];
    end
  end

endmodule

// File: logic/store_queue.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module store_queue import ldst_pkg::*, mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic                  dp_en_i,
  input  logic                  st_vld_i,
  input  logic [`SQ_IDX_W-1:0]  sq_idx_i,
  input  logic [63:0]           st_addr_i,
  input  logic [63:0]           st_data_i,
  input  logic                  retire_i,
  input  logic [63:0]           search_addr_i,
  input  logic [`SQ_IDX_W-1:0]  search_pos_i,
  input  logic [`SQ_IDX_W-1:0]  query_pos_i,
  output logic [`SQ_IDX_W-1:0]  tail_o,
  output logic                  full_o,
  output logic                  fwd_hit_o,
  output logic [63:0]           fwd_data_o,
  output logic                  older_unknown_o,
  output mem_wr_t               mem_wr_o
);

  sq_entry_t              q [`SQ_DEPTH];
  logic [`SQ_IDX_W-1:0]   head;
  logic [`SQ_IDX_W-1:0]   tail;
  logic [`SQ_IDX_W:0]     count;
  logic [`SQ_IDX_W-1:0]   slot [`SQ_DEPTH];
  logic [`SQ_IDX_W-1:0]   search_dist;
  logic [`SQ_IDX_W-1:0]   query_dist;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
      for (int i = 0; i < `SQ_DEPTH; i++) begin
        q[i].valid    <= 1'b0;
        q[i].addr_vld <= 1'b0;
      end
    end else begin
      if (dp_en_i) begin
        q[tail].valid    <= 1'b1;
        q[tail].addr_vld <= 1'b0;
        tail             <= tail + 1'b1;
      end
      if (st_vld_i) begin
        q[sq_idx_i].addr_vld <= 1'b1;
        q[sq_idx_i].addr     <= st_addr_i;
        q[sq_idx_i].data     <= st_data_i;
      end
      if (retire_i) begin
        q[head].valid    <= 1'b0;
        q[head].addr_vld <= 1'b0;
        head             <= head + 1'b1;
      end
      case ({dp_en_i, retire_i})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Slot k is the k-th oldest entry counted from the head.
  for (genvar k = 0; k < `SQ_DEPTH; k++) begin : g_slot
    assign slot[k] = head + `SQ_IDX_W'(k);
  end

  // Stores older than a position sit between the head and that position.
  // A position equal to the head therefore has no older stores.
  assign search_dist = search_pos_i - head;
  assign query_dist  = query_pos_i - head;

  // Later matches override earlier ones, so the youngest older store wins.
  always_comb begin
    fwd_hit_o       = 1'b0;
    fwd_data_o      = '0;
    older_unknown_o = 1'b0;
    for (int k = 0; k < `SQ_DEPTH; k++) begin
      if ((`SQ_IDX_W'(k) < search_dist) && q[slot[k]].valid && q[slot[k]].addr_vld &&
          (q[slot[k]].addr == search_addr_i)) begin
        fwd_hit_o  = 1'b1;
        fwd_data_o = q[slot[k]].data;
      end
      if ((`SQ_IDX_W'(k) < query_dist) && q[slot[k]].valid && !q[slot[k]].addr_vld) begin
        older_unknown_o = 1'b1;
      end
    end
  end

  // The head store goes to memory on retire.
  assign mem_wr_o.en   = retire_i;
  assign mem_wr_o.addr = q[head].addr;
  assign mem_wr_o.data = q[head].data;

  assign tail_o = tail;
  assign full_o = (count == (`SQ_IDX_W+1)'(`SQ_DEPTH));

endmodule

// File: logic/lsq.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module lsq import ldst_pkg::*, mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,
  input  logic [63:0]           addr_i,
  input  logic [63:0]           st_data_i,
  input  logic                  st_vld_i,
  input  logic                  ld_vld_i,
  input  logic [`SQ_IDX_W-1:0]  sq_idx_i,
  input  ldst_result_t          ld_tag_i,
  input  logic                  rob_st_retire_en_i,
  input  logic                  dp_en_i,
  input  logic [`SQ_IDX_W-1:0]  rs_ld_position_i,
  input  logic [`SQ_IDX_W-1:0]  ex_ld_position_i,
  input  logic [63:0]           mem_rdata_i,
  output mem_rd_t               mem_rd_o,
  output mem_wr_t               mem_wr_o,
  output ldst_result_t          result_o,
  output logic                  ld_done_o,
  output logic [`SQ_IDX_W-1:0]  lsq_sq_tail_o,
  output logic                  lsq_sq_full_o,
  output logic                  lsq_ld_iss_en_o
);

  logic          fwd_hit;
  logic [63:0]   fwd_data;
  logic          older_unknown;
  logic          ld_done_q;
  logic          fwd_sel_q;
  logic [63:0]   fwd_data_q;
  ldst_result_t  tag_q;

  store_queue u_store_queue (
    .clk             (clk),
    .rst_i           (rst_i),
    .dp_en_i         (dp_en_i),
    .st_vld_i        (st_vld_i),
    .sq_idx_i        (sq_idx_i),
    .st_addr_i       (addr_i),
    .st_data_i       (st_data_i),
    .retire_i        (rob_st_retire_en_i),
    .search_addr_i   (addr_i),
    .search_pos_i    (ex_ld_position_i),
    .query_pos_i     (rs_ld_position_i),
    .tail_o          (lsq_sq_tail_o),
    .full_o          (lsq_sq_full_o),
    .fwd_hit_o       (fwd_hit),
    .fwd_data_o      (fwd_data),
    .older_unknown_o (older_unknown),
    .mem_wr_o        (mem_wr_o)
  );

  // Memory is only read when no older store supplies the data.
  assign mem_rd_o.en   = ld_vld_i & ~fwd_hit;
  assign mem_rd_o.addr = addr_i;

  // A load may issue once all older stores know their address.
  assign lsq_ld_iss_en_o = ~older_unknown;

  always_ff @(posedge clk) begin
    if (rst_i) begin
      ld_done_q <= 1'b0;
    end else begin
      ld_done_q <= ld_vld_i;
    end
  end

  // Forward decision and tags line up with the memory read data.
  always_ff @(posedge clk) begin
    if (ld_vld_i) begin
      fwd_sel_q  <= fwd_hit;
      fwd_data_q <= fwd_data;
      tag_q      <= ld_tag_i;
    end
  end

  assign ld_done_o         = ld_done_q;
  assign result_o.data     = fwd_sel_q ? fwd_data_q : mem_rdata_i;
  assign result_o.dest_tag = tag_q.dest_tag;
  assign result_o.rob_idx  = tag_q.rob_idx;

endmodule

// File: logic/fu_ldst.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module fu_ldst import ldst_pkg::*, mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,
  input  ldst_req_t             req_i,
  input  logic                  st_vld_i,
  input  logic                  ld_vld_i,
  input  logic [`SQ_IDX_W-1:0]  sq_idx_i,
  input  logic                  rob_st_retire_en_i,
  input  logic                  dp_en_i,
  input  logic [`SQ_IDX_W-1:0]  rs_ld_position_i,
  input  logic [`SQ_IDX_W-1:0]  ex_ld_position_i,
  input  logic [63:0]           mem_rdata_i,
  output mem_rd_t               mem_rd_o,
  output mem_wr_t               mem_wr_o,
  output ldst_result_t          result_o,
  output logic                  ld_done_o,
  output logic                  st_done_o,
  output logic [`SQ_IDX_W-1:0]  lsq_sq_tail_o,
  output logic                  lsq_sq_full_o,
  output logic                  lsq_ld_iss_en_o
);

  logic [63:0]   mem_disp;
  logic [63:0]   eff_addr;
  ldst_result_t  ld_tag;

  // Displacement is the sign-extended low half of the instruction.
  assign mem_disp = {{48{req_i.inst[15]}}, req_i.inst[15:0]};
  assign eff_addr = req_i.opb + mem_disp;

  // Stores finish as soon as address and data land in the queue.
  assign st_done_o = st_vld_i;

  // Tags ride along with the load, data is filled in by the lsq.
  assign ld_tag.data     = '0;
  assign ld_tag.dest_tag = req_i.dest_tag;
  assign ld_tag.rob_idx  = req_i.rob_idx;

  lsq u_lsq (
    .clk                (clk),
    .rst_i              (rst_i),
    .addr_i             (eff_addr),
    .st_data_i          (req_i.opa),
    .st_vld_i           (st_vld_i),
    .ld_vld_i           (ld_vld_i),
    .sq_idx_i           (sq_idx_i),
    .ld_tag_i           (ld_tag),
    .rob_st_retire_en_i (rob_st_retire_en_i),
    .dp_en_i            (dp_en_i),
    .rs_ld_position_i   (rs_ld_position_i),
    .ex_ld_position_i   (ex_ld_position_i),
    .mem_rdata_i        (mem_rdata_i),
    .mem_rd_o           (mem_rd_o),
    .mem_wr_o           (mem_wr_o),
    .result_o           (result_o),
    .ld_done_o          (ld_done_o),
    .lsq_sq_tail_o      (lsq_sq_tail_o),
    .lsq_sq_full_o      (lsq_sq_full_o),
    .lsq_ld_iss_en_o    (lsq_ld_iss_en_o)
  );

endmodule

// File: logic/ldst_top.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module ldst_top import ldst_pkg::*, mem_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_i,
  input  ldst_req_t             req_i,
  input  logic                  st_vld_i,
  input  logic                  ld_vld_i,
  input  logic [`SQ_IDX_W-1:0]  sq_idx_i,
  input  logic                  rob_st_retire_en_i,
  input  logic                  dp_en_i,
  input  logic [`SQ_IDX_W-1:0]  rs_ld_position_i,
  input  logic [`SQ_IDX_W-1:0]  ex_ld_position_i,
  output ldst_result_t          result_o,
  output logic                  ld_done_o,
  output logic                  st_done_o,
  output logic [`SQ_IDX_W-1:0]  lsq_sq_tail_o,
  output logic                  lsq_sq_full_o,
  output logic                  lsq_ld_iss_en_o
);

  mem_rd_t      mem_rd;
  mem_wr_t      mem_wr;
  logic [63:0]  mem_rdata;

  fu_ldst u_fu_ldst (
    .clk                (clk),
    .rst_i              (rst_i),
    .req_i              (req_i),
    .st_vld_i           (st_vld_i),
    .ld_vld_i           (ld_vld_i),
    .sq_idx_i           (sq_idx_i),
    .rob_st_retire_en_i (rob_st_retire_en_i),
    .dp_en_i            (dp_en_i),
    .rs_ld_position_i   (rs_ld_position_i),
    .ex_ld_position_i   (ex_ld_position_i),
    .mem_rdata_i        (mem_rdata),
    .mem_rd_o           (mem_rd),
    .mem_wr_o           (mem_wr),
    .result_o           (result_o),
    .ld_done_o          (ld_done_o),
    .st_done_o          (st_done_o),
    .lsq_sq_tail_o      (lsq_sq_tail_o),
    .lsq_sq_full_o      (lsq_sq_full_o),
    .lsq_ld_iss_en_o    (lsq_ld_iss_en_o)
  );

  data_mem u_data_mem (
    .clk     (clk),
    .rst_i   (rst_i),
    .rd_i    (mem_rd),
    .wr_i    (mem_wr),
    .rdata_o (mem_rdata)
  );

endmodule

// File: verif/ldst_properties.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module ldst_properties import ldst_pkg::*; (
  input  logic       clk,
  input  logic       rst_i,
  input  logic       dp_en_i,
  input  logic       retire_i,
  input  logic       full_i,
  input  sq_entry_t  q_i [`SQ_DEPTH]
);

  logic  empty;
  int    fail_cnt = 0;

  // Empty comes from the entry valid bits while full comes from the count.
  always_comb begin
    empty = 1'b1;
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      if (q_i[i].valid) begin
        empty = 1'b0;
      end
    end
  end

  // A dispatch needs a free entry.
  a_no_dispatch_full: assert property (@(posedge clk) disable iff (rst_i) dp_en_i |-> !full_i)
    else begin
      $error("Store dispatched while the store queue was full");
      fail_cnt++;
    end

  // A retire needs a store in the queue.
  a_no_retire_empty: assert property (@(posedge clk) disable iff (rst_i) retire_i |-> !empty)
    else begin
      $error("Store retired while the store queue was empty");
      fail_cnt++;
    end

  // Count and valid bits must agree at the extremes.
  a_full_not_empty: assert property (@(posedge clk) disable iff (rst_i) !(full_i && empty))
    else begin
      $error("Store queue reported full and empty together");
      fail_cnt++;
    end

endmodule

bind store_queue ldst_properties u_ldst_properties (
  .clk      (clk),
  .rst_i    (rst_i),
  .dp_en_i  (dp_en_i),
  .retire_i (retire_i),
  .full_i   (full_o),
  .q_i      (q)
);

// File: verif/ldst_tb.sv
`timescale 1ns/1ps
`include "ldst_config.svh"

module ldst_tb import ldst_pkg::*; ();

  // About 250 cycles of tests, with generous margin.
  localparam int TIMEOUT_CYCLES = 2000;

  logic                  clk;
  logic                  rst_i;
  ldst_req_t             req;
  logic                  st_vld, ld_vld, dp_en, retire;
  logic [`SQ_IDX_W-1:0]  sq_idx, rs_pos, ex_pos, sq_tail;
  ldst_result_t          result;
  logic                  ld_done, st_done, sq_full, ld_iss_en;

  // Reference memory and model store queue.
  logic [63:0]           ref_mem [`DMEM_WORDS];
  logic                  mq_vld [`SQ_DEPTH];
  logic                  mq_avld [`SQ_DEPTH];
  logic [63:0]           mq_addr [`SQ_DEPTH];
  logic [63:0]           mq_data [`SQ_DEPTH];
  logic [`SQ_IDX_W-1:0]  m_head, m_tail;
  int                    m_count;
  ldst_result_t          exp_q [$];
  logic                  ld_prev;
  int                    err_cnt, chk_cnt, seed, tag_ctr, asrt_cnt;

  ldst_top DUT (
    .clk                (clk),
    .rst_i              (rst_i),
    .req_i              (req),
    .st_vld_i           (st_vld),
    .ld_vld_i           (ld_vld),
    .sq_idx_i           (sq_idx),
    .rob_st_retire_en_i (retire),
    .dp_en_i            (dp_en),
    .rs_ld_position_i   (rs_pos),
    .ex_ld_position_i   (ex_pos),
    .result_o           (result),
    .ld_done_o          (ld_done),
    .st_done_o          (st_done),
    .lsq_sq_tail_o      (sq_tail),
    .lsq_sq_full_o      (sq_full),
    .lsq_ld_iss_en_o    (ld_iss_en)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Watchdog expired before the tests completed");
    $display("Some tests failed");
    $finish;
  end

  task automatic compare_result(input ldst_result_t got, input ldst_result_t exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @%0t: load result data %h tag %0d rob %0d, expected data %h tag %0d rob %0d",
               $time, got.data, got.dest_tag, got.rob_idx, exp.data, exp.dest_tag, exp.rob_idx);
    end
  endtask

  task automatic compare_bit(input logic got, input logic exp, input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @%0t: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic compare_idx(input logic [`SQ_IDX_W-1:0] got, input logic [`SQ_IDX_W-1:0] exp,
                             input string what);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("FAIL @%0t: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  function automatic logic [63:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  function automatic logic [63:0] calc_addr(input logic [63:0] base, input logic [15:0] disp);
    return base + {{48{disp[15]}}, disp};
  endfunction

  // Youngest matching store older than pos, else memory.
  function automatic logic [63:0] predict_load(input logic [63:0] addr,
                                               input logic [`SQ_IDX_W-1:0] pos);
    logic [`SQ_IDX_W-1:0]  e;
    logic [63:0]           data;
    data = ref_mem[addr[`DW_OFFSET_W +: `DMEM_IDX_W]];
    e = m_head;
    while (e != pos) begin
      if (mq_vld[e] && mq_avld[e] && mq_addr[e] == addr) begin
        data = mq_data[e];
      end
      e = e + 1'b1;
    end
    return data;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
    st_vld = 1'b0;
    ld_vld = 1'b0;
    dp_en  = 1'b0;
    retire = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) next_cycle();
  endtask

  task automatic dispatch_store(output logic [`SQ_IDX_W-1:0] idx);
    next_cycle();
    compare_idx(sq_tail, m_tail, "store queue tail");
    compare_bit(sq_full, m_count == `SQ_DEPTH, "store queue full");
    idx = m_tail;
    dp_en = 1'b1;
    mq_vld[m_tail] = 1'b1;
    mq_avld[m_tail] = 1'b0;
    m_tail = m_tail + 1'b1;
    m_count++;
  endtask

  task automatic execute_store(input logic [`SQ_IDX_W-1:0] idx, input logic [63:0] base,
                               input logic [15:0] disp, input logic [63:0] data);
    next_cycle();
    st_vld = 1'b1;
    sq_idx = idx;
    req.opa = data;
    req.opb = base;
    req.inst = {16'($random(seed)), disp};
    mq_avld[idx] = 1'b1;
    mq_addr[idx] = calc_addr(base, disp);
    mq_data[idx] = data;
  endtask

  task automatic retire_store();
    next_cycle();
    if (!mq_avld[m_head]) begin
      err_cnt++;
      $display("Test sequence tried to retire a store that has no address");
    end
    retire = 1'b1;
    ref_mem[mq_addr[m_head][`DW_OFFSET_W +: `DMEM_IDX_W]] = mq_data[m_head];
    mq_vld[m_head] = 1'b0;
    m_head = m_head + 1'b1;
    m_count--;
  endtask

  // Holds the load at its position until the DUT grants issue.
  task automatic wait_issue(input logic [`SQ_IDX_W-1:0] pos);
    int n;
    n = 0;
    rs_pos = pos;
    @(negedge clk);
    while (!ld_iss_en && n < 50) begin
      @(negedge clk);
      n++;
    end
    if (!ld_iss_en) begin
      err_cnt++;
      $display("Load at position %0d never received issue permission", pos);
    end
  endtask

  task automatic issue_load(input logic [63:0] base, input logic [15:0] disp,
                            input logic [`SQ_IDX_W-1:0] pos);
    ldst_result_t exp;
    wait_issue(pos);
    next_cycle();
    req.opa = rand64();
    req.opb = base;
    req.inst = {16'($random(seed)), disp};
    req.dest_tag = tag_ctr[`PRF_IDX_W-1:0];
    req.rob_idx = `ROB_IDX_W'(tag_ctr * 3);
    ex_pos = pos;
    ld_vld = 1'b1;
    exp.data = predict_load(calc_addr(base, disp), pos);
    exp.dest_tag = req.dest_tag;
    exp.rob_idx = req.rob_idx;
    exp_q.push_back(exp);
    tag_ctr++;
  endtask

  // Result monitor, samples mid-cycle.
  always @(negedge clk) begin
    if (!rst_i) begin
      compare_bit(st_done, st_vld, "st_done");
      compare_bit(ld_done, ld_prev, "ld_done");
      if (ld_done && exp_q.size() != 0) begin
        compare_result(result, exp_q.pop_front());
      end
      ld_prev = ld_vld;
    end
  end

  task automatic check_reset_state();
    @(negedge clk);
    compare_idx(sq_tail, 0, "tail after reset");
    compare_bit(sq_full, 1'b0, "full after reset");
    issue_load(64'h0, 16'h0000, m_tail);
    issue_load(64'h1f8, 16'h0000, m_tail);
    issue_load(64'h88, 16'hfff8, m_tail);
    idle(2);
  endtask

  task automatic store_then_load();
    logic [`SQ_IDX_W-1:0] s;
    dispatch_store(s);
    execute_store(s, 64'h100, 16'h0008, rand64());
    retire_store();
    issue_load(64'h118, 16'hfff0, m_tail);
    issue_load(64'h108, 16'h0000, m_tail);
    idle(2);
  endtask

  task automatic forward_from_queue();
    logic [`SQ_IDX_W-1:0]  s1, s2, s3, pos_old;
    dispatch_store(s1);
    dispatch_store(s2);
    execute_store(s1, 64'h40, 16'h0000, rand64());
    execute_store(s2, 64'h50, 16'hfff0, rand64());
    issue_load(64'h40, 16'h0000, m_tail);
    issue_load(64'h40, 16'h0000, s2);
    issue_load(64'h48, 16'h0000, m_tail);
    pos_old = m_tail;
    dispatch_store(s3);
    execute_store(s3, 64'h40, 16'h0000, rand64());
    issue_load(64'h40, 16'h0000, pos_old);
    repeat (3) retire_store();
    issue_load(64'h40, 16'h0000, m_tail);
    idle(2);
  endtask

  task automatic hold_until_addr_known();
    logic [`SQ_IDX_W-1:0] s;
    dispatch_store(s);
    next_cycle();
    rs_pos = m_tail;
    @(negedge clk);
    compare_bit(ld_iss_en, 1'b0, "issue enable behind unknown store");
    next_cycle();
    rs_pos = s;
    @(negedge clk);
    compare_bit(ld_iss_en, 1'b1, "issue enable ahead of unknown store");
    execute_store(s, 64'h180, 16'h0000, rand64());
    next_cycle();
    rs_pos = m_tail;
    @(negedge clk);
    compare_bit(ld_iss_en, 1'b1, "issue enable after store executes");
    retire_store();
    idle(1);
  endtask

  task automatic fill_and_wrap();
    logic [`SQ_IDX_W-1:0]  ids [9];
    logic [`SQ_IDX_W-1:0]  start;
    start = m_tail;
    for (int n = 0; n < 8; n++) begin
      dispatch_store(ids[n]);
    end
    next_cycle();
    @(negedge clk);
    compare_bit(sq_full, 1'b1, "full after eight dispatches");
    compare_idx(sq_tail, start, "wrapped tail");
    for (int n = 0; n < 8; n++) begin
      execute_store(ids[n], 64'h100, 16'(8 * n), rand64());
    end
    retire_store();
    next_cycle();
    @(negedge clk);
    compare_bit(sq_full, 1'b0, "full after one retire");
    dispatch_store(ids[8]);
    execute_store(ids[8], 64'h1c0, 16'h0000, rand64());
    repeat (8) retire_store();
    issue_load(64'h110, 16'h0000, m_tail);
    idle(2);
  endtask

  task automatic back_to_back_loads();
    logic [`SQ_IDX_W-1:0]  s, pos_before;
    pos_before = m_tail;
    dispatch_store(s);
    issue_load(64'h100, 16'h0000, pos_before);
    issue_load(64'h108, 16'h0000, pos_before);
    issue_load(64'h1c0, 16'h0000, pos_before);
    execute_store(s, 64'h1f0, 16'h0000, rand64());
    issue_load(64'h1f0, 16'h0000, m_tail);
    issue_load(64'h118, 16'h0000, m_tail);
    retire_store();
    idle(3);
  endtask

  initial begin
    req = '0;
    st_vld = 1'b0;
    ld_vld = 1'b0;
    dp_en = 1'b0;
    retire = 1'b0;
    sq_idx = '0;
    rs_pos = '0;
    ex_pos = '0;
    ld_prev = 1'b0;
    seed = 32'h224e_7daa;
    err_cnt = 0;
    chk_cnt = 0;
    tag_ctr = 1;
    m_head = '0;
    m_tail = '0;
    m_count = 0;
    for (int i = 0; i < `DMEM_WORDS; i++) begin
      ref_mem[i] = '0;
    end
    for (int i = 0; i < `SQ_DEPTH; i++) begin
      mq_vld[i] = 1'b0;
      mq_avld[i] = 1'b0;
    end
    rst_i = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    rst_i = 1'b0;
    check_reset_state();
    store_then_load();
    forward_from_queue();
    hold_until_addr_known();
    fill_and_wrap();
    back_to_back_loads();
    if (exp_q.size() != 0) begin
      err_cnt++;
      $display("%0d load results never arrived", exp_q.size());
    end
    asrt_cnt = DUT.u_fu_ldst.u_lsq.u_store_queue.u_ldst_properties.fail_cnt;
    $display("Checks: %0d, errors: %0d, assertion failures: %0d", chk_cnt, err_cnt, asrt_cnt);
    if (err_cnt == 0 && asrt_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: build.f
+incdir+logic
logic/ldst_pkg.sv
logic/mem_pkg.sv
logic/data_mem.sv
logic/store_queue.sv
logic/lsq.sv
logic/fu_ldst.sv
logic/ldst_top.sv
verif/ldst_properties.sv
verif/ldst_tb.sv
